// ==== seq_pkg.sv ====
package seq_pkg;

    // word address into the 256-entry instruction store.
    typedef logic [7:0]  pc_t;

    // interrupt target is given in bytes, four bytes per word.
    typedef logic [9:0]  byte_addr_t;

    typedef logic [15:0] ins_word_t;
    typedef logic [11:0] operand_t;
    typedef logic [11:0] acc_t;
    typedef logic [2:0]  credit_t;

    // upper nibble of an instruction word.
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        XOR  = 4'd3,
        OUT  = 4'd4,
        JMP  = 4'd5,
        CALL = 4'd6,
        RET  = 4'd7,
        HALT = 4'd8
    } opcode_t;

    typedef enum logic [1:0] {
        REDIR_JUMP,
        REDIR_CALL,
        REDIR_RET
    } redirect_kind_t;

    typedef enum logic [1:0] {
        PC_IDLE,
        PC_COUNT,
        PC_REDIRECT,
        PC_HALTED
    } pc_state_t;

endpackage

// ==== seq_ifc.sv ====
`timescale 1ns/1ns

// operations from decode into the execute queue, credits flow back.
interface dec_ex_if import seq_pkg::*; ();
    logic     valid;
    opcode_t  opcode;
    operand_t operand;
    logic     credit;

    modport decode (output valid, output opcode, output operand, input credit);
    modport execute (input valid, input opcode, input operand, output credit);
endinterface

// control flow resolved in decode, applied by the program counter.
interface redirect_if import seq_pkg::*; ();
    logic           valid;
    redirect_kind_t kind;
    pc_t            target;
    pc_t            link;

    modport decode (output valid, output kind, output target, output link);
    modport pc (input valid, input kind, input target, input link);
endinterface

// ==== program_counter.sv ====
`timescale 1ns/1ns

module program_counter import seq_pkg::*;
#(
    parameter int STACK_DEPTH = 4
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       irq,
    input  byte_addr_t irq_addr,
    input  pc_t        load_count,
    input  logic       fetch_grant,
    input  logic       halt,
    redirect_if.pc     redir,
    output pc_t        fetch_addr,
    output logic       fetch_req,
    output logic       flush
);
    localparam int SPW = $clog2(STACK_DEPTH + 1);
    localparam int IW  = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;

    pc_state_t      state;
    pc_t            stack_mem [STACK_DEPTH];
    logic [SPW-1:0] sp;
    logic [IW-1:0]  push_idx;
    logic [IW-1:0]  top_idx;
    logic           irq_q;
    logic           irq_pend;
    logic           irq_seen;
    logic           take_redir;
    logic           take_irq;
    logic           push;
    pc_t            push_addr;
    pc_t            pop_addr;

    assign irq_seen   = irq_pend | (irq & ~irq_q);
    assign take_redir = (state == PC_COUNT) && !halt && redir.valid;
    // a redirect from decode goes first, the interrupt waits one turn.
    assign take_irq   = (state == PC_COUNT) && !halt && !redir.valid && irq_seen;
    assign flush      = take_redir | take_irq;

    assign fetch_req = (state == PC_COUNT) && !halt && fetch_grant
                       && (fetch_addr < load_count);

    // the word fetched in the interrupt cycle is dropped, so resume at fetch_addr.
    assign push      = take_irq | (take_redir && redir.kind == REDIR_CALL);
    assign push_addr = take_irq ? fetch_addr : redir.link;
    assign push_idx  = IW'(sp);
    assign top_idx   = IW'(sp - SPW'(1));
    assign pop_addr  = (sp != '0) ? stack_mem[top_idx] : fetch_addr;

    always_ff @(posedge clk)
    begin
        if (push && sp < SPW'(STACK_DEPTH))
        begin
            stack_mem[push_idx] <= push_addr;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= PC_IDLE;
            fetch_addr <= '0;
            sp         <= '0;
            irq_q      <= 1'b0;
            irq_pend   <= 1'b0;
        end
        else
        begin
            irq_q <= irq;
            if (take_irq)
                irq_pend <= 1'b0;
            else if (irq & ~irq_q)
                irq_pend <= 1'b1;

            // stack overflow and underflow leave sp unchanged.
            if (push && sp < SPW'(STACK_DEPTH))
                sp <= sp + SPW'(1);
            else if (take_redir && redir.kind == REDIR_RET && sp != '0)
                sp <= sp - SPW'(1);

            case (state)
                PC_IDLE:
                begin
                    if (start)
                        state <= PC_COUNT;
                end
                PC_COUNT:
                begin
                    if (halt)
                        state <= PC_HALTED;
                    else if (take_redir)
                    begin
                        state      <= PC_REDIRECT;
                        fetch_addr <= (redir.kind == REDIR_RET) ? pop_addr : redir.target;
                    end
                    else if (take_irq)
                    begin
                        state      <= PC_REDIRECT;
                        fetch_addr <= irq_addr[9:2];
                    end
                    else if (fetch_req)
                        fetch_addr <= fetch_addr + pc_t'(1);
                end
                // one idle cycle while the flushed word drains.
                PC_REDIRECT:
                begin
                    state <= halt ? PC_HALTED : PC_COUNT;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

// ==== ins_store.sv ====
`timescale 1ns/1ns

module ins_store import seq_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load_valid,
    input  pc_t       load_addr,
    input  ins_word_t load_data,
    input  pc_t       fetch_addr,
    input  logic      fetch_req,
    output ins_word_t fetch_data,
    output logic      fetch_valid
);
    ins_word_t mem [256];

    // software load port.
    always_ff @(posedge clk)
    begin
        if (load_valid)
        begin
            mem[load_addr] <= load_data;
        end
    end

    // registered read, data appears the cycle after the request.
    always_ff @(posedge clk)
    begin
        if (fetch_req)
        begin
            fetch_data <= mem[fetch_addr];
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            fetch_valid <= 1'b0;
        end
        else
        begin
            fetch_valid <= fetch_req;
        end
    end

endmodule

// ==== ins_decode.sv ====
`timescale 1ns/1ns

module ins_decode import seq_pkg::*;
#(
    parameter int EXEC_SLOTS = 2
)
(
    input  logic       clk,
    input  logic       rst,
    input  ins_word_t  fetch_data,
    input  logic       fetch_valid,
    input  pc_t        fetch_addr,
    input  logic       flush,
    dec_ex_if.decode   ex,
    redirect_if.decode redir,
    output logic       fetch_grant,
    output logic       halt
);
    opcode_t  op;
    operand_t operand;
    pc_t      word_addr;
    credit_t  cred;
    logic     flush_q;
    logic     take;
    logic     is_ctrl;
    logic     to_exec;

    assign op      = opcode_t'(fetch_data[15:12]);
    assign operand = fetch_data[11:0];

    // words behind a redirect, an interrupt or a halt are discarded.
    assign take    = fetch_valid && !flush_q && !halt;
    assign is_ctrl = (op == JMP) || (op == CALL) || (op == RET);
    assign to_exec = take && !is_ctrl;

    assign redir.valid  = take && is_ctrl;
    assign redir.target = operand[7:0];
    assign redir.link   = word_addr + pc_t'(1);

    always_comb
    begin
        case (op)
            JMP:     redir.kind = REDIR_JUMP;
            CALL:    redir.kind = REDIR_CALL;
            default: redir.kind = REDIR_RET;
        endcase
    end

    // the word arriving now still holds one credit in reserve.
    assign fetch_grant = cred > credit_t'(take);

    // address of the word that arrives in the next cycle.
    always_ff @(posedge clk)
    begin
        word_addr <= fetch_addr;
        if (to_exec)
        begin
            ex.opcode  <= op;
            ex.operand <= operand;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ex.valid <= 1'b0;
            cred     <= credit_t'(EXEC_SLOTS);
            flush_q  <= 1'b0;
            halt     <= 1'b0;
        end
        else
        begin
            ex.valid <= to_exec;
            flush_q  <= flush;
            cred     <= cred + credit_t'(ex.credit) - credit_t'(to_exec);
            if (to_exec && op == HALT)
                halt <= 1'b1;
        end
    end

endmodule

// ==== ins_execute.sv ====
`timescale 1ns/1ns

module ins_execute import seq_pkg::*;
#(
    parameter int EXEC_SLOTS     = 2,
    parameter int RESULT_CREDITS = 4
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      out_credit,
    dec_ex_if.execute ex,
    output logic      out_valid,
    output acc_t      out_data,
    output logic      drained
);
    localparam int PW = (EXEC_SLOTS > 1) ? $clog2(EXEC_SLOTS) : 1;
    localparam int CW = $clog2(EXEC_SLOTS + 1);

    opcode_t       q_op      [EXEC_SLOTS];
    operand_t      q_operand [EXEC_SLOTS];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    acc_t          acc;
    credit_t       rcred;
    opcode_t       head_op;
    operand_t      head_operand;
    logic          retire;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(EXEC_SLOTS - 1)) ? '0 : ptr + PW'(1);
    endfunction

    assign head_op      = q_op[rd_ptr];
    assign head_operand = q_operand[rd_ptr];

    // an OUT stays at the head until the result queue has room.
    assign retire    = (count != '0) && (head_op != OUT || rcred != '0);
    assign out_valid = retire && head_op == OUT;
    assign out_data  = acc;
    assign ex.credit = retire;
    assign drained   = (count == '0) && !ex.valid;

    always_ff @(posedge clk)
    begin
        if (ex.valid)
        begin
            q_op[wr_ptr]      <= ex.opcode;
            q_operand[wr_ptr] <= ex.operand;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            acc    <= '0;
            rcred  <= credit_t'(RESULT_CREDITS);
        end
        else
        begin
            if (ex.valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (retire)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + CW'(ex.valid) - CW'(retire);
            rcred <= rcred + credit_t'(out_credit) - credit_t'(out_valid);
            if (retire)
            begin
                // 12-bit arithmetic wraps modulo 4096.
                case (head_op)
                    ADD:     acc <= acc + head_operand;
                    SUB:     acc <= acc - head_operand;
                    XOR:     acc <= acc ^ head_operand;
                    default: acc <= acc;
                endcase
            end
        end
    end

endmodule

// ==== result_port.sv ====
`timescale 1ns/1ns

module result_port import seq_pkg::*;
#(
    parameter int RESULT_CREDITS = 4
)
(
    input  logic clk,
    input  logic rst,
    input  logic out_valid,
    input  acc_t out_data,
    input  logic result_credit,
    output logic out_credit,
    output logic result_valid,
    output acc_t result_data,
    output logic empty
);
    localparam int PW = (RESULT_CREDITS > 1) ? $clog2(RESULT_CREDITS) : 1;
    localparam int CW = $clog2(RESULT_CREDITS + 1);

    acc_t          q_data [RESULT_CREDITS];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    credit_t       ext_cred;
    logic          send;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(RESULT_CREDITS - 1)) ? '0 : ptr + PW'(1);
    endfunction

    // one value per cycle while the consumer has granted credit.
    assign send       = (count != '0) && (ext_cred != '0);
    assign out_credit = send;
    assign empty      = (count == '0) && !result_valid;

    always_ff @(posedge clk)
    begin
        if (out_valid)
            q_data[wr_ptr] <= out_data;
        if (send)
            result_data <= q_data[rd_ptr];
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            ext_cred     <= credit_t'(RESULT_CREDITS);
            result_valid <= 1'b0;
        end
        else
        begin
            if (out_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (send)
                rd_ptr <= next_ptr(rd_ptr);
            count        <= count + CW'(out_valid) - CW'(send);
            ext_cred     <= ext_cred + credit_t'(result_credit) - credit_t'(send);
            result_valid <= send;
        end
    end

endmodule

// ==== seq_top.sv ====
`timescale 1ns/1ns

module seq_top import seq_pkg::*;
#(
    parameter int STACK_DEPTH    = 4,
    parameter int EXEC_SLOTS     = 2,
    parameter int RESULT_CREDITS = 4
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load_valid,
    input  pc_t        load_addr,
    input  ins_word_t  load_data,
    input  pc_t        load_count,
    input  logic       start,
    input  logic       irq,
    input  byte_addr_t irq_addr,
    output logic       result_valid,
    output acc_t       result_data,
    input  logic       result_credit,
    output logic       halted
);
    dec_ex_if   dec_ex ();
    redirect_if redir ();

    pc_t       fetch_addr;
    logic      fetch_req;
    logic      flush;
    logic      fetch_grant;
    logic      halt;
    ins_word_t fetch_data;
    logic      fetch_valid;
    logic      out_valid;
    acc_t      out_data;
    logic      out_credit;
    logic      drained;
    logic      empty;

    program_counter #(.STACK_DEPTH(STACK_DEPTH)) pc_i (
        .clk, .rst, .start, .irq, .irq_addr, .load_count, .fetch_grant, .halt,
        .redir(redir.pc), .fetch_addr, .fetch_req, .flush
    );

    ins_store store_i (
        .clk, .rst, .load_valid, .load_addr, .load_data, .fetch_addr, .fetch_req,
        .fetch_data, .fetch_valid
    );

    ins_decode #(.EXEC_SLOTS(EXEC_SLOTS)) dec_i (
        .clk, .rst, .fetch_data, .fetch_valid, .fetch_addr, .flush,
        .ex(dec_ex.decode), .redir(redir.decode), .fetch_grant, .halt
    );

    ins_execute #(.EXEC_SLOTS(EXEC_SLOTS), .RESULT_CREDITS(RESULT_CREDITS)) ex_i (
        .clk, .rst, .out_credit, .ex(dec_ex.execute), .out_valid, .out_data, .drained
    );

    result_port #(.RESULT_CREDITS(RESULT_CREDITS)) res_i (
        .clk, .rst, .out_valid, .out_data, .result_credit, .out_credit,
        .result_valid, .result_data, .empty
    );

    // done once HALT is decoded and every queue behind it is empty.
    assign halted = halt & drained & empty;

endmodule

// ==== seq_asserts.sv ====
`timescale 1ns/1ns

module seq_asserts import seq_pkg::*;
#(
    parameter int STACK_DEPTH    = 4,
    parameter int RESULT_CREDITS = 4
)
(
    input logic           clk,
    input logic           rst,
    input logic           start,
    input logic           fetch_req,
    input logic           flush,
    input logic           redir_valid,
    input redirect_kind_t redir_kind,
    input logic           result_valid,
    input logic           result_credit
);
    int   depth;
    int   credits;
    logic pushes;
    logic pops;
    logic started;

    // an interrupt is a flush without a redirect and pushes like a call.
    assign pushes = flush && (!redir_valid || redir_kind == REDIR_CALL);
    assign pops   = flush && redir_valid && redir_kind == REDIR_RET;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            depth   <= 0;
            credits <= RESULT_CREDITS;
            started <= 1'b0;
        end
        else
        begin
            if (pushes)
                depth <= depth + 1;
            else if (pops && depth > 0)
                depth <= depth - 1;
            credits <= credits + int'(result_credit) - int'(result_valid);
            if (start)
                started <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst) result_valid |-> credits > 0)
        else $error("result_valid without a result credit");

    assert property (@(posedge clk) disable iff (!rst) depth <= STACK_DEPTH)
        else $error("return stack nesting deeper than STACK_DEPTH");

    assert property (@(posedge clk) disable iff (!rst) pops |-> depth > 0)
        else $error("return with an empty return stack");

    // no fetch from reset until the first start.
    assert property (@(posedge clk) !started |-> !fetch_req)
        else $error("fetch_req high after reset before start");

endmodule

bind seq_top seq_asserts #(
    .STACK_DEPTH(STACK_DEPTH),
    .RESULT_CREDITS(RESULT_CREDITS)
) asserts_i (
    .clk,
    .rst,
    .start,
    .fetch_req,
    .flush,
    .redir_valid(redir.valid),
    .redir_kind(redir.kind),
    .result_valid,
    .result_credit
);

// ==== seq_tb.sv ====
`timescale 1ns/1ns

module seq_tb import seq_pkg::*;
();
    localparam int MAX_WORDS      = 512;
    localparam int RESULT_CREDITS = 4;
    localparam int RUN_LIMIT      = 3000;
    localparam int QUIET_TIME     = 60;

    logic       clk;
    logic       rst;
    logic       load_valid;
    pc_t        load_addr;
    ins_word_t  load_data;
    pc_t        load_count;
    logic       start;
    logic       irq;
    byte_addr_t irq_addr;
    logic       result_valid;
    acc_t       result_data;
    logic       result_credit;
    logic       halted;

    logic [15:0] cases_mem [MAX_WORDS];
    acc_t        expected [32];
    int          ptr;
    int          case_num;
    int          case_errors;
    int          n_pass;
    int          n_fail;
    int          n_exp;
    int          got;
    int          owed;
    int          avail;
    int          gap_cnt;
    int          gap_max;
    int          hold_cycles;
    int          irq_cycle;
    int          cycle;

    seq_top #(
        .STACK_DEPTH(4),
        .EXEC_SLOTS(2),
        .RESULT_CREDITS(RESULT_CREDITS)
    ) dut_i (
        .clk, .rst, .load_valid, .load_addr, .load_data, .load_count, .start,
        .irq, .irq_addr, .result_valid, .result_data, .result_credit, .halted
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int next_field();
        int value;
        value = int'(cases_mem[ptr]);
        ptr++;
        return value;
    endfunction

    task automatic apply_reset();
        rst           = 1'b0;
        load_valid    = 1'b0;
        start         = 1'b0;
        irq           = 1'b0;
        result_credit = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        if (result_valid !== 1'b0 || halted !== 1'b0)
        begin
            $display("case %0d: outputs are not low after reset", case_num);
            case_errors++;
        end
    endtask

    task automatic load_program(input int n_words);
        int i;
        for (i = 0; i < n_words; i++)
        begin
            @(negedge clk);
            load_valid = 1'b1;
            load_addr  = pc_t'(i);
            load_data  = cases_mem[ptr + i];
        end
        @(negedge clk);
        load_valid = 1'b0;
        ptr += n_words;
    endtask

    task automatic take_result();
        if (avail == 0)
        begin
            $display("case %0d: result_valid rose with no credit held", case_num);
            case_errors++;
        end
        else
            avail--;
        owed++;
        if (got >= n_exp)
        begin
            $display("case %0d: unexpected extra result %h", case_num, result_data);
            case_errors++;
        end
        else if (result_data !== expected[got])
        begin
            $display("ERROR at %0t: case %0d result %0d is %h, expected %h",
                     $time, case_num, got, result_data, expected[got]);
            case_errors++;
        end
        got++;
    endtask

    // one cycle of the consumer, credits go back after a random gap.
    task automatic tick();
        @(negedge clk);
        cycle++;
        start = 1'b0;
        if (result_valid)
            take_result();
        result_credit = 1'b0;
        if (cycle >= hold_cycles && owed > 0)
        begin
            if (gap_cnt == 0)
            begin
                result_credit = 1'b1;
                owed--;
                avail++;
                gap_cnt = int'($urandom % (gap_max + 1));
            end
            else
                gap_cnt--;
        end
        irq = (irq_cycle != 0 && cycle == irq_cycle);
    endtask

    task automatic run_case();
        int         i;
        int         n_words;
        int         expect_halt;
        int         quiet;
        int         waited;
        pc_t        count_field;
        byte_addr_t irq_field;
        logic       done;

        n_words     = next_field();
        count_field = pc_t'(next_field());
        irq_cycle   = next_field();
        irq_field   = byte_addr_t'(next_field());
        hold_cycles = next_field();
        gap_max     = next_field();
        expect_halt = next_field();
        n_exp       = next_field();
        case_errors = 0;
        apply_reset();
        load_count = count_field;
        irq_addr   = irq_field;
        load_program(n_words);
        for (i = 0; i < n_exp; i++)
            expected[i] = acc_t'(next_field());

        got     = 0;
        owed    = 0;
        avail   = RESULT_CREDITS;
        gap_cnt = 0;
        cycle   = 0;
        quiet   = 0;
        waited  = 0;
        done    = 1'b0;
        @(negedge clk);
        start = 1'b1;
        while (!done && waited < RUN_LIMIT)
        begin
            tick();
            waited++;
            if (halted && got < n_exp)
            begin
                $display("case %0d: halted rose with %0d of %0d results", case_num, got, n_exp);
                case_errors++;
                done = 1'b1;
            end
            else if (expect_halt != 0)
                done = halted;
            else if (halted)
            begin
                $display("case %0d: halted rose with no HALT inside load_count", case_num);
                case_errors++;
                done = 1'b1;
            end
            else
            begin
                if (got >= n_exp)
                    quiet++;
                done = (quiet >= QUIET_TIME);
            end
        end
        if (!done)
        begin
            $display("case %0d: timed out with %0d of %0d results", case_num, got, n_exp);
            case_errors++;
        end

        if (case_errors == 0)
        begin
            $display("case %0d passed", case_num);
            n_pass++;
        end
        else
        begin
            $display("case %0d failed with %0d errors", case_num, case_errors);
            n_fail++;
        end
    endtask

    initial
    begin
        void'($urandom(7277));
        rst           = 1'b0;
        load_valid    = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        load_count    = '0;
        start         = 1'b0;
        irq           = 1'b0;
        irq_addr      = '0;
        result_credit = 1'b0;
        n_pass        = 0;
        n_fail        = 0;
        case_num      = 0;
        ptr           = 0;
        $readmemh("seq_cases.txt", cases_mem);

        while (cases_mem[ptr] != 16'h0000 && ptr < MAX_WORDS - 8)
        begin
            case_num++;
            run_case();
        end
        if (case_num == 0)
        begin
            $display("no cases were read from seq_cases.txt");
            n_fail++;
        end

        $display("%0d cases run, %0d passed, %0d failed", case_num, n_pass, n_fail);
        if (n_fail == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== seq_cases.txt ====
// header: words load_count irq_cycle irq_byte_addr credit_hold credit_gap expect_halt n_results
// then the program words from address 0, then the expected results, all hex; 0000 ends the list
000B 000B 0000 0000 0000 0003 0001 0005
1123 4000 2023 4000 3FFF 4000 1105 4000 2010 4000 8000
0123 0100 0EFF 0004 0FF4
0012 0012 0000 0000 0000 0002 0001 0004
1001 5004 1100 4000 4000 600A 2002 4000 8000 4000 1010 600F 1020 4000 7000 3003 4000 7000
0001 0012 0032 0030
0016 0016 000E 0044 0000 0002 0001 0004
1005 4000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1003 4000 8000 30F0 4000 30F0 4000 7000
0005 00F5 0005 0008
0005 0004 0000 0000 0000 0001 0000 0002
1007 4000 1001 4000 8000
0007 0008
000C 000C 0000 0000 0050 000C 0001 0007
1011 4000 4000 1022 4000 1033 4000 4000 4000 2066 4000 8000
0011 0011 0033 0066 0066 0066 0000
0000

// ==== list.f ====
seq_pkg.sv
seq_ifc.sv
program_counter.sv
ins_store.sv
ins_decode.sv
ins_execute.sv
result_port.sv
seq_top.sv
seq_asserts.sv
seq_tb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module seq_tb -f list.f -o seq_sim || exit 1
obj_dir/seq_sim > sim.log 2>&1 || echo "simulator returned a failing status" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && echo "simulation FAILED" && exit 1
grep -q "%Error" sim.log && echo "simulation FAILED on an assertion" && exit 1
grep -q "All tests passed!" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation PASSED"
exit 0
